// ==== hw/button_overlay.sv ====
// Draws twelve 8x8 button glyphs scaled to 32x32
// Lit glyph pixel is green when its button is pressed, red otherwise
// Colour is registered, one cycle behind pos; black outside the window
`timescale 1ns/1ps

module button_overlay (
  input  logic               clk,
  input  logic               rst_n,
  input  piyc_pkg::vga_pos_t pos,
  input  piyc_pkg::buttons_t buttons,
  output piyc_pkg::rgb_t     color
);
  import piyc_pkg::*;

  localparam int N_GLYPH = 12;

  // Bitmaps, one byte per row, top row in the high byte, leftmost pixel in bit 7
  // Index matches buttons_t bit order, so b is 11 and r is 0
  localparam logic [N_GLYPH-1:0][63:0] GLYPHS = {
    64'h7c_66_66_7c_66_66_7c_00, // b
    64'hc3_66_3c_18_18_18_18_18, // y
    64'h18_24_42_81_81_42_24_18, // select, diamond outline
    64'h3c_40_40_20_10_08_04_78, // start, an S
    64'h10_38_7c_fe_10_10_10_10, // up arrow
    64'h10_10_10_10_fe_7c_38_10, // down arrow
    64'h10_30_70_ff_70_30_10_00, // left arrow
    64'h08_0c_0e_ff_0e_0c_08_00, // right arrow
    64'h3c_66_66_7e_66_66_66_00, // a
    64'hc3_66_3c_18_18_3c_66_c3, // x
    64'h60_60_60_60_60_7e_7e_00, // l
    64'h7c_66_66_7c_78_6c_66_00  // r
  };

  // Top-left corners, same order as GLYPHS
  localparam coord_t [N_GLYPH-1:0] GLYPH_X = {
    10'd512, 10'd464, 10'd264, 10'd328, // b y select start
    10'd96,  10'd96,  10'd48,  10'd144, // up down left right
    10'd560, 10'd512, 10'd32,  10'd550  // a x l r
  };
  localparam coord_t [N_GLYPH-1:0] GLYPH_Y = {
    10'd296, 10'd240, 10'd240, 10'd240,
    10'd192, 10'd288, 10'd240, 10'd240,
    10'd240, 10'd184, 10'd92,  10'd92
  };

  logic [N_GLYPH-1:0] lit;     // Pixel falls on a set bitmap bit
  logic [N_GLYPH-1:0] pressed;
  logic               any_lit;
  logic               any_pressed;
  rgb_t               color_d;

  // Per-glyph hit test and bitmap lookup
  always_comb begin
    coord_t     dx;
    coord_t     dy;
    logic [2:0] row;
    logic [2:0] col;
    for (int i = 0; i < N_GLYPH; i++) begin
      dx  = pos.x - GLYPH_X[i]; // Wraps large when left of the box
      dy  = pos.y - GLYPH_Y[i];
      row = dy[GLYPH_SHIFT +: 3];
      col = dx[GLYPH_SHIFT +: 3];
      if ((pos.x >= GLYPH_X[i]) && (dx < coord_t'(GLYPH_SIZE)) &&
          (pos.y >= GLYPH_Y[i]) && (dy < coord_t'(GLYPH_SIZE))) begin
        lit[i] = GLYPHS[i][{~row, ~col}]; // Bit 63 - 8*row - col
      end else begin
        lit[i] = 1'b0;
      end
    end
  end

  assign pressed     = lit & buttons; // Struct bits line up with glyph index
  assign any_lit     = |lit;
  assign any_pressed = |pressed;

  // Pressed wins over lit; blanking forces black
  always_comb begin
    if (!pos.display_on) color_d = BLACK;
    else if (any_pressed) color_d = GREEN;
    else if (any_lit) color_d = RED;
    else color_d = BLACK;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) color <= BLACK;
    else color <= color_d;
  end

endmodule

// ==== hw/pad_decode.sv ====
// Pad word decoder with presence gating and a fixed button remap
// Purely combinational
// All ones on the wire means no controller, then no button is pressed
`timescale 1ns/1ps

module pad_decode (
  input  piyc_pkg::pad_word_u pad_word,
  output piyc_pkg::buttons_t  buttons  // Logical order
);
  import piyc_pkg::*;

  logic     absent;
  buttons_t phys; // Physical buttons after the presence gate

  assign absent = &pad_word.raw;   // Pulled-up data line reads 0xfff
  assign phys   = absent ? '0 : pad_word.btn;

  // Deliberately scrambled, the tester shows which glyph a press lands on
  assign buttons.left   = phys.a;
  assign buttons.right  = phys.x;
  assign buttons.up     = phys.start;
  assign buttons.down   = phys.b;
  assign buttons.a      = phys.right;
  assign buttons.b      = phys.up;
  assign buttons.x      = phys.down;
  assign buttons.y      = phys.select;
  assign buttons.l      = phys.r;    // Shoulders swapped
  assign buttons.r      = phys.l;
  assign buttons.select = phys.y;
  assign buttons.start  = phys.left;

endmodule

// ==== hw/pad_serial_rx.sv ====
// Gamepad serial receiver, 12 bits, first bit lands in the MSB
// Pins are asynchronous; each must stay stable at least 4 clk cycles
// Word holds all ones after reset, which reads as no controller
`timescale 1ns/1ps

module pad_serial_rx #(
  parameter int sync_stages = 2 // Synchronizer depth, 1 or more
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pad_data,
  input  logic                pad_clk,
  input  logic                pad_latch,
  output piyc_pkg::pad_word_u pad_word
);
  import piyc_pkg::*;

  // The three pad wires move through the synchronizer together
  typedef struct packed {
    logic data;
    logic shift; // Pad shift clock
    logic latch;
  } pad_pins_t;

  pad_pins_t [sync_stages-1:0] sync_q; // Index 0 sees the pins first
  pad_pins_t                   pins_s; // Synchronized pins
  logic                        shift_prev;
  logic                        latch_prev;
  logic                        shift_rise;
  logic                        latch_rise;
  logic [11:0]                 shift_reg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= '{data: pad_data, shift: pad_clk, latch: pad_latch};
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pins_s     = sync_q[sync_stages-1];
  assign shift_rise = pins_s.shift & ~shift_prev;
  assign latch_rise = pins_s.latch & ~latch_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_prev   <= 1'b0;
      latch_prev   <= 1'b0;
      shift_reg    <= '1;
      pad_word.raw <= '1; // Absent until the first latch
    end else begin
      shift_prev <= pins_s.shift;
      latch_prev <= pins_s.latch;
      if (shift_rise) shift_reg <= {shift_reg[10:0], pins_s.data}; // New bit at LSB
      if (latch_rise) pad_word.raw <= shift_reg;
    end
  end

endmodule

// ==== hw/piyc_pkg.sv ====
// Shared types and constants for the gamepad tester
// VGA numbers are for 640x480 at a 25 MHz pixel clock, one pixel per clk
// Button order follows the gamepad shift order, b first (MSB)
package piyc_pkg;

  // Raster timing, in pixels and lines
  parameter int H_VISIBLE = 640;
  parameter int H_FRONT   = 16;
  parameter int H_SYNC    = 96;
  parameter int H_BACK    = 48;
  parameter int H_TOTAL   = 800;

  parameter int V_VISIBLE = 480;
  parameter int V_FRONT   = 10;
  parameter int V_SYNC    = 2;
  parameter int V_BACK    = 33;
  parameter int V_TOTAL   = 525;

  // On-screen glyph is an 8x8 bitmap scaled by 4
  parameter int GLYPH_SIZE  = 32;
  parameter int GLYPH_SHIFT = 2;

  typedef logic [9:0] coord_t; // Pixel column or line number

  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   display_on; // Inside the 640x480 window
  } vga_pos_t;

  // 2 bits per channel, Tiny VGA style
  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } rgb_t;

  parameter rgb_t BLACK = '{r: 2'b00, g: 2'b00, b: 2'b00};
  parameter rgb_t RED   = '{r: 2'b11, g: 2'b00, b: 2'b00};
  parameter rgb_t GREEN = '{r: 2'b00, g: 2'b11, b: 2'b00};

  // One bit per button, 1 = pressed
  typedef struct packed {
    logic b;      // First bit on the wire
    logic y;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
    logic a;
    logic x;
    logic l;
    logic r;      // Last bit on the wire
  } buttons_t;

  // Latched pad word, raw for presence test, btn for the fields
  typedef union packed {
    logic [11:0] raw;
    buttons_t    btn;
  } pad_word_u;

endpackage

// ==== hw/piyc_top.sv ====
// Gamepad button tester with VGA output
// Pad wires on ui_in[6:4] (data, shift clock, latch); other inputs unused
// uo_out follows the Tiny VGA pin order
`timescale 1ns/1ps

module piyc_top #(
  parameter int sync_stages = 2 // Pad input synchronizer depth
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out
);
  import piyc_pkg::*;

  vga_pos_t  pos;
  logic      hsync;
  logic      vsync;
  pad_word_u pad_word;
  buttons_t  buttons;
  rgb_t      color;

  vga_timing u_vga_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos),
    .hsync (hsync),
    .vsync (vsync)
  );

  pad_serial_rx #(
    .sync_stages (sync_stages)
  ) u_pad_serial_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .pad_data  (ui_in[6]),
    .pad_clk   (ui_in[5]),
    .pad_latch (ui_in[4]),
    .pad_word  (pad_word)
  );

  pad_decode u_pad_decode (
    .pad_word (pad_word),
    .buttons  (buttons)
  );

  button_overlay u_button_overlay (
    .clk     (clk),
    .rst_n   (rst_n),
    .pos     (pos),
    .buttons (buttons),
    .color   (color)
  );

  // Tiny VGA order: low colour bits with hsync, high bits with vsync
  assign uo_out = {hsync, color.b[0], color.g[0], color.r[0],
                   vsync, color.b[1], color.g[1], color.r[1]};

endmodule

// ==== hw/vga_timing.sv ====
// 640x480 raster scan, one pixel per clk
// Sync pulses are active low and decoded combinationally from the counters
// x=0, y=0 in the first cycle after reset
`timescale 1ns/1ps

module vga_timing (
  input  logic               clk,
  input  logic               rst_n,
  output piyc_pkg::vga_pos_t pos,
  output logic               hsync,
  output logic               vsync
);
  import piyc_pkg::*;

  // Sync windows derived from the package timing
  localparam int HS_START = H_VISIBLE + H_FRONT;  // 656
  localparam int HS_END   = HS_START + H_SYNC;    // 752, exclusive
  localparam int VS_START = V_VISIBLE + V_FRONT;  // 490
  localparam int VS_END   = VS_START + V_SYNC;    // 492, exclusive

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;

  assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
  assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

  // Pixel counter, line counter steps on each wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      if (v_last) v_cnt <= '0; // End of frame
      else v_cnt <= v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  // Low inside the sync windows
  assign hsync = !((h_cnt >= coord_t'(HS_START)) && (h_cnt < coord_t'(HS_END)));
  assign vsync = !((v_cnt >= coord_t'(VS_START)) && (v_cnt < coord_t'(VS_END)));

  assign pos.x          = h_cnt;
  assign pos.y          = v_cnt;
  assign pos.display_on = (h_cnt < coord_t'(H_VISIBLE)) && (v_cnt < coord_t'(V_VISIBLE));

endmodule

// ==== piyc_top.f ====
+incdir+tests
hw/piyc_pkg.sv
hw/vga_timing.sv
hw/pad_serial_rx.sv
hw/pad_decode.sv
hw/button_overlay.sv
hw/piyc_top.sv
tests/tb_piyc.sv

// ==== run.sh ====
#!/bin/sh
# Builds the gamepad tester testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_piyc -f piyc_top.f --Mdir obj_dir -o tb_piyc
./obj_dir/tb_piyc | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "Simulation ended without a result line, see $LOG"
  exit 1
fi
echo "Simulation passed"

// ==== tests/tb_piyc_tasks.svh ====
// Pad transfer and directed checks, included inside the tb_piyc module body
// Inputs change 1 ns after a rising edge, outputs are sampled on the falling edge
`ifndef TB_PIYC_TASKS_SVH
`define TB_PIYC_TASKS_SVH

  task automatic report_value(input string name, input int got, input int exp);
    error_count++;
    $display("[ERROR] %0d ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  // Wait n rising edges, then step past them to drive
  task automatic advance(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Colour back from the Tiny VGA pin order
  function automatic rgb_t pin_color(input logic [7:0] o);
    rgb_t c;
    c.r = {o[0], o[4]};
    c.g = {o[1], o[5]};
    c.b = {o[2], o[6]};
    return c;
  endfunction

  // Physical to logical buttons, all ones on the wire means no pad
  function automatic logic [11:0] expected_buttons(input logic [11:0] word);
    pad_word_u w;
    buttons_t  p;
    buttons_t  q;
    w.raw = word;
    p = (word == 12'hfff) ? buttons_t'(12'h000) : w.btn;
    q.left   = p.a;
    q.right  = p.x;
    q.up     = p.start;
    q.down   = p.b;
    q.a      = p.right;
    q.b      = p.up;
    q.x      = p.down;
    q.y      = p.select;
    q.l      = p.r;
    q.r      = p.l;
    q.select = p.y;
    q.start  = p.left;
    return q;
  endfunction

  task automatic check_reset_pins();
    check_count++;
    if ({uo_out[6:4], uo_out[2:0]} !== 6'b0)
      report_value("uo_out colour bits", int'({uo_out[6:4], uo_out[2:0]}), 0);
    if (uo_out[7] !== 1'b1) report_value("hsync", int'(uo_out[7]), 1);
    if (uo_out[3] !== 1'b1) report_value("vsync", int'(uo_out[3]), 1);
  endtask

  // Four cycles in reset, pins checked in each and in the first cycle after
  task automatic reset_and_check();
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_reset_pins();
    end
    @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_reset_pins();
  endtask

  // 12 bits, b first, data set while the shift clock is low
  task automatic send_pad(input logic [11:0] word);
    logic [11:0] bits;
    bits = word;
    advance(1);
    repeat (12) begin
      ui_in[6] = bits[11];
      ui_in[5] = 1'b0;
      advance(PHASE_CYCLES);
      ui_in[5] = 1'b1; // Receiver shifts here
      advance(PHASE_CYCLES);
      bits = bits << 1;
    end
    ui_in[5] = 1'b0;
    advance(PHASE_CYCLES);
    ui_in[4] = 1'b1; // Latch edge copies the word
    advance(PHASE_CYCLES);
    ui_in[4] = 1'b0;
    ui_in[6] = 1'b1;
    advance(PHASE_CYCLES);
  endtask

  // Every pixel of one frame, blanking included, starting at (0,0)
  task automatic check_frame(input logic [11:0] btn, input string label);
    rgb_t got;
    rgb_t exp;
    @(negedge clk);
    while (!(pvalid && px == 0 && py == 0)) @(negedge clk);
    repeat (FRAME_CYCLES) begin
      got = pin_color(uo_out);
      exp = expected_color(px, py, btn);
      check_count++;
      if (got !== exp)
        report_value($sformatf("%s colour (%0d,%0d)", label, px, py), int'(got), int'(exp));
      @(negedge clk);
    end
  endtask

  // Random lit pixels of every glyph, checked in the next pass over the glyph band
  task automatic check_press(input logic [11:0] word, input string label);
    logic [11:0] btn;
    int          dx;
    int          dy;
    rgb_t        got;
    rgb_t        exp;
    btn = expected_buttons(word);
    send_pad(word);
    for (int g = 0; g < 12; g++) begin
      repeat (PROBES_PER_GLYPH) begin
        do begin
          dx = $urandom_range(GLYPH_SIZE - 1, 0);
          dy = $urandom_range(GLYPH_SIZE - 1, 0);
        end while (!glyph_bit(g, GLYPH_X0[g] + dx, GLYPH_Y0[g] + dy)); // Lit bits only
        probe_map[GLYPH_Y0[g] + dy][GLYPH_X0[g] + dx] = 1'b1;
      end
    end
    @(negedge clk);
    while (!(pvalid && px == 0 && py == BAND_TOP)) @(negedge clk);
    while (py < BAND_END) begin
      if (px < H_VISIBLE && probe_map[py][px]) begin
        probe_map[py][px] = 1'b0; // Map is clean for the next test
        got = pin_color(uo_out);
        exp = expected_color(px, py, btn);
        check_count++;
        if (got !== exp)
          report_value($sformatf("%s colour (%0d,%0d)", label, px, py), int'(got), int'(exp));
      end
      @(negedge clk);
    end
  endtask

  // Low width and period of an active-low sync pin, in clk cycles
  task automatic check_sync_pulse(input int pin, input string name, input int exp_low,
                                  input int exp_period);
    int low_len;
    int period;
    low_len = 0;
    @(negedge clk);
    while (uo_out[3'(pin)] == 1'b0) @(negedge clk); // Skip a pulse already running
    while (uo_out[3'(pin)] == 1'b1) @(negedge clk);
    while (uo_out[3'(pin)] == 1'b0) begin
      low_len++;
      @(negedge clk);
    end
    period = low_len;
    while (uo_out[3'(pin)] == 1'b1) begin
      period++;
      @(negedge clk);
    end
    check_count += 2;
    if (low_len != exp_low) report_value({name, " low cycles"}, low_len, exp_low);
    if (period != exp_period) report_value({name, " period cycles"}, period, exp_period);
  endtask

`endif

// ==== tests/tb_piyc.sv ====
// Directed testbench for the gamepad tester, 10 ns clk, one pixel per cycle
// Pixel tracker mirrors the raster from reset release and runs one cycle behind for the colour
// Glyph bitmaps and corners are an independent copy of the button artwork
`timescale 1ns/1ps

module tb_piyc;
  import piyc_pkg::*;

  localparam int CLK_PERIOD       = 10;
  localparam int FRAME_CYCLES     = H_TOTAL * V_TOTAL;             // 420000
  localparam int WATCHDOG_NS      = 6 * FRAME_CYCLES * CLK_PERIOD; // Six frames, 25.2 ms
  localparam int PHASE_CYCLES     = 4;  // Each pad clock or latch phase
  localparam int PROBES_PER_GLYPH = 8;
  localparam int BAND_TOP         = 92;  // First line holding any glyph
  localparam int BAND_END         = 328; // Line after the lowest glyph

  // Index follows buttons_t bit order, r is 0 and b is 11
  localparam logic [63:0] GLYPH_BM [12] = '{
    64'h7c66667c786c6600, 64'h6060606060_7e7e00, 64'hc3663c18183c66c3, // r l x
    64'h3c66667e66666600, 64'h080c0eff0e0c0800, 64'h103070ff70301000, // a right left
    64'h10101010fe7c3810, 64'h10387cfe10101010, 64'h3c40402010080478, // down up start
    64'h1824428181422418, 64'hc3663c1818181818, 64'h7c66667c66667c00  // select y b
  };
  localparam int GLYPH_X0 [12] = '{550, 32, 512, 560, 144, 48, 96, 96, 328, 264, 464, 512};
  localparam int GLYPH_Y0 [12] = '{92, 92, 184, 240, 240, 240, 288, 192, 240, 240, 240, 296};

  logic       clk;
  logic       rst_n;
  logic [7:0] ui_in;
  logic [7:0] uo_out;

  int   tx;      // Raster position of the current cycle
  int   ty;
  int   px;      // Position that the colour on uo_out belongs to
  int   py;
  logic pvalid;  // Colour belongs to a tracked pixel
  int   error_count;
  int   check_count;
  bit   probe_map [V_VISIBLE][H_VISIBLE]; // Pixels picked for the press checks

  piyc_top #(
    .sync_stages (2)
  ) dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .ui_in  (ui_in),
    .uo_out (uo_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Own raster counters, then one register stage to line up with the colour
  always @(posedge clk) begin
    if (!rst_n) begin
      tx <= 0;
      ty <= 0;
    end else if (tx == H_TOTAL - 1) begin
      tx <= 0;
      ty <= (ty == V_TOTAL - 1) ? 0 : ty + 1; // Frame wrap
    end else begin
      tx <= tx + 1;
    end
    px     <= tx;
    py     <= ty;
    pvalid <= rst_n;
  end

  // Bitmap bit of glyph g at pixel (x, y), 0 outside its 32x32 box
  function automatic logic glyph_bit(input int g, input int x, input int y);
    int          row;
    int          col;
    logic [63:0] bm;
    bm = GLYPH_BM[g];
    if (x < GLYPH_X0[g] || x >= GLYPH_X0[g] + GLYPH_SIZE) return 1'b0;
    if (y < GLYPH_Y0[g] || y >= GLYPH_Y0[g] + GLYPH_SIZE) return 1'b0;
    row = (y - GLYPH_Y0[g]) >> GLYPH_SHIFT;
    col = (x - GLYPH_X0[g]) >> GLYPH_SHIFT;
    return bm[6'(63 - 8 * row - col)]; // Top row in the high byte, left pixel in its MSB
  endfunction

  // Green beats red, anything else black
  function automatic rgb_t expected_color(input int x, input int y, input logic [11:0] btn);
    logic lit_any;
    logic press_any;
    lit_any   = 1'b0;
    press_any = 1'b0;
    if (x >= H_VISIBLE || y >= V_VISIBLE) return BLACK; // Blanking
    for (int g = 0; g < 12; g++) begin
      if (glyph_bit(g, x, y)) begin
        lit_any = 1'b1;
        if (btn[4'(g)]) press_any = 1'b1;
      end
    end
    if (press_any) return GREEN;
    if (lit_any) return RED;
    return BLACK;
  endfunction

  `include "tb_piyc_tasks.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h978629d7));
    rst_n = 1'b0;
    ui_in = 8'h40; // Pad data idles high, shift clock and latch low
    reset_and_check();
    check_frame(expected_buttons(12'hfff), "idle"); // Nothing latched yet, pad absent
    check_press(12'h008, "phys a");
    check_press(12'h010, "phys right");
    check_press(12'hffe, "all but r");
    check_press(12'hfff, "all ones");
    check_sync_pulse(7, "hsync", H_SYNC, H_TOTAL);
    check_sync_pulse(3, "vsync", V_SYNC * H_TOTAL, FRAME_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule
